// File: hdl/fixedPointAlu.sv
`timescale 1ns/1ps

module fixedPointAlu
(
	input synFiltPkg::aluOp op,
	input logic signed [15:0] a,
	input logic signed [15:0] b,
	input logic signed [31:0] acc,
	output logic signed [31:0] result
);

	localparam logic signed [31:0] maxWord = 32'sh7fffffff;
	localparam logic signed [31:0] minWord = 32'sh80000000;

	logic signed [31:0] rawProduct;
	logic signed [31:0] product;

	// Clamp a 33-bit sum back into 32 bits
	function automatic logic signed [31:0] saturate(input logic signed [32:0] wide);
		logic signed [31:0] clamped;
		if (wide[32] != wide[31])
			clamped = wide[32] ? minWord : maxWord;
		else
			clamped = wide[31:0];
		return clamped;
	endfunction

	//////////////////////////////
	// Fractional multiply
	//////////////////////////////

	always_comb
	begin
		rawProduct = a * b;
		// Q15 by Q15 doubled into Q31
		// Only the product of two -32768 values overflows
		if (rawProduct == 32'sh40000000)
			product = maxWord;
		else
			product = rawProduct <<< 1;
	end

	//////////////////////////////
	// Opcode select
	//////////////////////////////

	always_comb
	begin
		case (op)
			synFiltPkg::opMult:
				result = product;
			synFiltPkg::opMsu:
				result = saturate({acc[31], acc} - {product[31], product});
			// Operand pair taken as one word, high half in a
			synFiltPkg::opAdd:
				result = saturate({acc[31], acc} + {a[15], a, b});
			default:
				result = product;
		endcase
	end

endmodule

// File: hdl/longShiftLeft.sv
`timescale 1ns/1ps

module longShiftLeft
(
	input logic clk,
	input logic reset,
	input logic ready,
	input logic [31:0] var1,
	input logic [15:0] numShift,
	output logic done,
	output logic [31:0] out
);

	logic busy;
	logic [15:0] remaining;
	logic [31:0] stepped;

	// One saturating step
	// A clamped value stays clamped on later steps
	always_comb
	begin
		if ($signed(out) > 32'sh3fffffff)
			stepped = 32'h7fffffff;
		else if ($signed(out) < 32'shc0000000)
			stepped = 32'h80000000;
		else
			stepped = out << 1;
	end

	// Step counter and done pulse
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			remaining <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (!busy)
			begin
				if (ready)
				begin
					remaining <= numShift;
					busy <= (numShift != 16'd0);
					done <= (numShift == 16'd0);
				end
			end
			else
			begin
				remaining <= remaining - 16'd1;
				if (remaining == 16'd1)
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!busy && ready)
			out <= var1;
		else if (busy)
			out <= stepped;
	end

endmodule

// File: hdl/scratchMemory.sv
`timescale 1ns/1ps
`include "synFilt_config.svh"

module scratchMemory
(
	input logic clk,
	input synFiltPkg::memWrite write,
	input logic [`SYN_ADDR_W-1:0] readAddr,
	output logic [`SYN_WORD_W-1:0] readData
);

	localparam int memDepth = 1 << `SYN_ADDR_W;

	logic [`SYN_WORD_W-1:0] words [memDepth];

	// Write port
	always_ff @(posedge clk)
	begin
		if (write.writeEn)
			words[write.addr] <= write.data;
	end

	// Registered read, one cycle after the address
	always_ff @(posedge clk)
	begin
		readData <= words[readAddr];
	end

endmodule

// File: hdl/synFiltControl.sv
`timescale 1ns/1ps
`include "synFilt_config.svh"

module synFiltControl
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic [`SYN_ADDR_W-1:0] xAddr,
	input logic [`SYN_ADDR_W-1:0] aAddr,
	input logic [`SYN_ADDR_W-1:0] yAddr,
	input logic [`SYN_ADDR_W-1:0] fMemAddr,
	input logic update,
	input logic [`SYN_WORD_W-1:0] memIn,
	output synFiltPkg::memWrite memOut,
	output logic [`SYN_ADDR_W-1:0] readAddr,
	output synFiltPkg::aluOp op,
	output logic signed [15:0] aluA,
	output logic signed [15:0] aluB,
	output logic signed [31:0] aluAcc,
	input logic signed [31:0] aluResult,
	output logic shlReady,
	output logic [31:0] shlVar1,
	output logic [15:0] shlNumShift,
	input logic shlDone,
	input logic [31:0] shlOut,
	output logic done
);

	localparam int sampleW = $clog2(`SYN_FRAME);
	localparam int tapW = $clog2(`SYN_ORDER + 1);
	localparam logic [`SYN_ADDR_W-1:0] copyOffset = `SYN_FRAME - `SYN_ORDER;

	synFiltPkg::synState state;
	logic [sampleW-1:0] n;
	logic [tapW-1:0] j;
	logic updateReg;
	logic [`SYN_ADDR_W-1:0] xBase;
	logic [`SYN_ADDR_W-1:0] aBase;
	logic [`SYN_ADDR_W-1:0] yBase;
	logic [`SYN_ADDR_W-1:0] fBase;
	logic signed [31:0] acc;
	logic signed [15:0] coef;
	logic [`SYN_ADDR_W-1:0] pastAddr;
	logic lastSample;
	logic lastTap;

	assign lastSample = (n == sampleW'(`SYN_FRAME - 1));
	assign lastTap = (j == tapW'(`SYN_ORDER));

	// y[n-j] from the output area, else from the filter memory (oldest first)
	always_comb
	begin
		if (`SYN_ADDR_W'(n) >= `SYN_ADDR_W'(j))
			pastAddr = yBase + `SYN_ADDR_W'(n) - `SYN_ADDR_W'(j);
		else
			pastAddr = fBase + `SYN_ADDR_W'(`SYN_ORDER) + `SYN_ADDR_W'(n) - `SYN_ADDR_W'(j);
	end

	//////////////////////////////
	// Memory side
	//////////////////////////////

	always_comb
	begin
		case (state)
			synFiltPkg::loadFirst:
				readAddr = aBase;
			synFiltPkg::readCoef:
				readAddr = aBase + `SYN_ADDR_W'(j);
			synFiltPkg::readPast:
				readAddr = (j == '0) ? xBase + `SYN_ADDR_W'(n) : pastAddr;
			synFiltPkg::copyRead:
				readAddr = yBase + copyOffset + `SYN_ADDR_W'(j);
			default:
				readAddr = aBase;
		endcase
	end

	always_comb
	begin
		memOut.writeEn = 1'b0;
		memOut.addr = yBase + `SYN_ADDR_W'(n);
		// Rounded high half, sign-extended into the word
		memOut.data = {{16{acc[31]}}, acc[31:16]};
		if (state == synFiltPkg::writeOut)
			memOut.writeEn = 1'b1;
		else if (state == synFiltPkg::copyWrite)
		begin
			memOut.writeEn = 1'b1;
			memOut.addr = fBase + `SYN_ADDR_W'(j);
			memOut.data = memIn;
		end
	end

	//////////////////////////////
	// Arithmetic side
	//////////////////////////////

	always_comb
	begin
		op = (j == '0) ? synFiltPkg::opMult : synFiltPkg::opMsu;
		aluA = coef;
		aluB = memIn[15:0];
		aluAcc = acc;
		if (state == synFiltPkg::round)
		begin
			// Add 0x8000 before taking the high half
			op = synFiltPkg::opAdd;
			aluA = 16'sd0;
			aluB = 16'sh8000;
		end
	end

	assign shlReady = (state == synFiltPkg::shiftStart);
	assign shlVar1 = acc;
	assign shlNumShift = 16'(`SYN_SHIFT);
	assign done = (state == synFiltPkg::finish);

	//////////////////////////////
	// Sequencer
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= synFiltPkg::idle;
			n <= '0;
			j <= '0;
			updateReg <= 1'b0;
		end
		else
		begin
			case (state)
				synFiltPkg::idle:
				begin
					if (start)
					begin
						updateReg <= update;
						n <= '0;
						state <= synFiltPkg::loadFirst;
					end
				end
				synFiltPkg::loadFirst:
				begin
					j <= '0;
					state <= synFiltPkg::readPast;
				end
				synFiltPkg::readCoef:
					state <= synFiltPkg::readPast;
				synFiltPkg::readPast:
					state <= synFiltPkg::accumulate;
				synFiltPkg::accumulate:
				begin
					if (lastTap)
						state <= synFiltPkg::shiftStart;
					else
					begin
						j <= j + tapW'(1);
						state <= synFiltPkg::readCoef;
					end
				end
				synFiltPkg::shiftStart:
					state <= synFiltPkg::shiftWait;
				synFiltPkg::shiftWait:
				begin
					if (shlDone)
						state <= synFiltPkg::round;
				end
				synFiltPkg::round:
					state <= synFiltPkg::writeOut;
				synFiltPkg::writeOut:
				begin
					if (!lastSample)
					begin
						n <= n + sampleW'(1);
						state <= synFiltPkg::loadFirst;
					end
					else if (updateReg)
					begin
						j <= '0;
						state <= synFiltPkg::copyRead;
					end
					else
						state <= synFiltPkg::finish;
				end
				synFiltPkg::copyRead:
					state <= synFiltPkg::copyWrite;
				synFiltPkg::copyWrite:
				begin
					if (j == tapW'(`SYN_ORDER - 1))
						state <= synFiltPkg::finish;
					else
					begin
						j <= j + tapW'(1);
						state <= synFiltPkg::copyRead;
					end
				end
				default:
					state <= synFiltPkg::idle;
			endcase
		end
	end

	// Job bases, coefficient and accumulator
	always_ff @(posedge clk)
	begin
		if (state == synFiltPkg::idle && start)
		begin
			xBase <= xAddr;
			aBase <= aAddr;
			yBase <= yAddr;
			fBase <= fMemAddr;
		end
		if (state == synFiltPkg::readPast)
			coef <= memIn[15:0];
		if (state == synFiltPkg::accumulate || state == synFiltPkg::round)
			acc <= aluResult;
		else if (state == synFiltPkg::shiftWait && shlDone)
			acc <= shlOut;
	end

endmodule

// File: hdl/synFiltPipe.sv
`timescale 1ns/1ps
`include "synFilt_config.svh"

module synFiltPipe
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic [`SYN_ADDR_W-1:0] xAddr,
	input logic [`SYN_ADDR_W-1:0] aAddr,
	input logic [`SYN_ADDR_W-1:0] yAddr,
	input logic [`SYN_ADDR_W-1:0] fMemAddr,
	input logic update,
	input synFiltPkg::hostAccess host,
	output logic [`SYN_WORD_W-1:0] memIn,
	output logic done
);

	synFiltPkg::memWrite ctrlWrite;
	synFiltPkg::memWrite memWriteSel;
	logic [`SYN_ADDR_W-1:0] ctrlReadAddr;
	logic [`SYN_ADDR_W-1:0] memReadAddr;
	synFiltPkg::aluOp aluOpSel;
	logic signed [15:0] aluA;
	logic signed [15:0] aluB;
	logic signed [31:0] aluAcc;
	logic signed [31:0] aluResult;
	logic shlReady;
	logic [31:0] shlVar1;
	logic [15:0] shlNumShift;
	logic shlDone;
	logic [31:0] shlOut;

	synFiltControl fsm
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.xAddr(xAddr),
		.aAddr(aAddr),
		.yAddr(yAddr),
		.fMemAddr(fMemAddr),
		.update(update),
		.memIn(memIn),
		.memOut(ctrlWrite),
		.readAddr(ctrlReadAddr),
		.op(aluOpSel),
		.aluA(aluA),
		.aluB(aluB),
		.aluAcc(aluAcc),
		.aluResult(aluResult),
		.shlReady(shlReady),
		.shlVar1(shlVar1),
		.shlNumShift(shlNumShift),
		.shlDone(shlDone),
		.shlOut(shlOut),
		.done(done)
	);

	scratchMemory convMem
	(
		.clk(clk),
		.write(memWriteSel),
		.readAddr(memReadAddr),
		.readData(memIn)
	);

	fixedPointAlu filtAlu
	(
		.op(aluOpSel),
		.a(aluA),
		.b(aluB),
		.acc(aluAcc),
		.result(aluResult)
	);

	longShiftLeft filtShl
	(
		.clk(clk),
		.reset(reset),
		.ready(shlReady),
		.var1(shlVar1),
		.numShift(shlNumShift),
		.done(shlDone),
		.out(shlOut)
	);

	//////////////////////////////
	// Host access selector
	//////////////////////////////

	// Host takes both memory ports while select is high
	always_comb
	begin
		if (host.select)
		begin
			memWriteSel = host.write;
			memReadAddr = host.readAddr;
		end
		else
		begin
			memWriteSel = ctrlWrite;
			memReadAddr = ctrlReadAddr;
		end
	end

endmodule

// File: hdl/synFiltPkg.sv
`include "synFilt_config.svh"

package synFiltPkg;

	// Sequencer states
	typedef enum logic [15:0]
	{
		idle,
		loadFirst,
		readCoef,
		readPast,
		accumulate,
		shiftStart,
		shiftWait,
		round,
		writeOut,
		copyRead,
		copyWrite,
		finish
	} synState;

	// Arithmetic unit opcodes
	typedef enum logic [1:0]
	{
		opMult,
		opMsu,
		opAdd
	} aluOp;

	// One memory write port
	typedef struct packed
	{
		logic writeEn;
		logic [`SYN_ADDR_W-1:0] addr;
		logic [`SYN_WORD_W-1:0] data;
	} memWrite;

	// Host side of the memory selector
	typedef struct packed
	{
		logic select;
		logic [`SYN_ADDR_W-1:0] readAddr;
		memWrite write;
	} hostAccess;

endpackage

// File: hdl/synFilt_config.svh
`ifndef SYN_FILT_CONFIG_SVH
`define SYN_FILT_CONFIG_SVH

//////////////////////////////
// Filter geometry
//////////////////////////////

// Taps after a[0], also the number of past outputs kept
`define SYN_ORDER 10

// Samples per subframe
`define SYN_FRAME 40

//////////////////////////////
// Memory and arithmetic
//////////////////////////////

`define SYN_ADDR_W 12
`define SYN_WORD_W 32

// Scaling before rounding to the high half
`define SYN_SHIFT 3

`endif

// File: runSim.sh
#!/bin/sh
# Build and run the synthesis filter testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module synFiltTb -f synFilt.f -o synFiltSim

# A fatal stop in the simulation still leaves the log for the search below
./obj_dir/synFiltSim 2>&1 | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation finished cleanly"

// File: sim/synFiltTb.sv
`timescale 1ns/1ps
`include "synFilt_config.svh"

module synFiltTb;

	localparam int order = `SYN_ORDER;
	localparam int frame = `SYN_FRAME;
	// Three cycles per tap plus shift, round and write for each sample
	localparam int runCycles = frame * (3 * order + `SYN_SHIFT + 8) + 2 * order + 4;
	// Five filter runs plus host traffic, about doubled
	localparam int maxCycles = 12 * runCycles;

	localparam logic [`SYN_ADDR_W-1:0] aBase = 'h000;
	localparam logic [`SYN_ADDR_W-1:0] xBase = 'h100;
	localparam logic [`SYN_ADDR_W-1:0] yBase = 'h200;
	localparam logic [`SYN_ADDR_W-1:0] fBase = 'h300;
	localparam logic [`SYN_ADDR_W-1:0] yAlt = 'h400;

	logic clk = 1'b0;
	logic reset;
	logic start;
	logic [`SYN_ADDR_W-1:0] xAddr;
	logic [`SYN_ADDR_W-1:0] aAddr;
	logic [`SYN_ADDR_W-1:0] yAddr;
	logic [`SYN_ADDR_W-1:0] fMemAddr;
	logic update;
	synFiltPkg::hostAccess host;
	logic [`SYN_WORD_W-1:0] memIn;
	logic done;

	integer seed;
	int cycleCount = 0;
	int doneCount = 0;
	logic doneLast;
	int xs[frame];
	int coefs[order + 1];
	int fmem[order];
	int yExp[frame];

	synFiltPipe uut
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.xAddr(xAddr),
		.aAddr(aAddr),
		.yAddr(yAddr),
		.fMemAddr(fMemAddr),
		.update(update),
		.host(host),
		.memIn(memIn),
		.done(done)
	);

	always #10 clk = ~clk;

	//////////////////////////////
	// Failure reporting
	//////////////////////////////

	task automatic stopWithFailure();
		$display("TESTBENCH FAILED");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic failMismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		stopWithFailure();
	endtask

	task automatic failText(input string text);
		$display("%s (at %0t ns)", text, $time);
		stopWithFailure();
	endtask

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount > maxCycles)
			failText("Timeout: the filter runs did not finish within the cycle limit");
	end

	// Done pulses counted mid-cycle
	always @(negedge clk)
	begin
		if (!reset && done)
			doneCount++;
	end

	always @(posedge clk)
	begin
		if (reset)
			doneLast <= 1'b0;
		else
			doneLast <= done;
	end

	donePulse: assert property (@(posedge clk) disable iff (reset) !(done && doneLast))
		else failText("done stayed high for more than one cycle");

	//////////////////////////////
	// Host memory access
	//////////////////////////////

	task automatic writeWord(input logic [`SYN_ADDR_W-1:0] addr, input logic [31:0] data);
		@(posedge clk);
		#1;
		host.select = 1'b1;
		host.write.writeEn = 1'b1;
		host.write.addr = addr;
		host.write.data = data;
	endtask

	// Data is taken one cycle after the address
	task automatic readWord(input logic [`SYN_ADDR_W-1:0] addr, output logic [31:0] data);
		@(posedge clk);
		#1;
		host.select = 1'b1;
		host.write.writeEn = 1'b0;
		host.readAddr = addr;
		@(posedge clk);
		#1;
		data = memIn;
	endtask

	task automatic checkWord(input logic [`SYN_ADDR_W-1:0] addr, input logic [31:0] expected,
		input string name);
		logic [31:0] got;
		readWord(addr, got);
		assert (got === expected)
			else failMismatch(name, expected, got);
	endtask

	task automatic loadJob();
		for (int j = 0; j <= order; j++)
			writeWord(aBase + `SYN_ADDR_W'(j), 32'(coefs[j]));
		for (int n = 0; n < frame; n++)
			writeWord(xBase + `SYN_ADDR_W'(n), 32'(xs[n]));
		for (int k = 0; k < order; k++)
			writeWord(fBase + `SYN_ADDR_W'(k), 32'(fmem[k]));
		@(posedge clk);
		#1;
		host = '0;
	endtask

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic longint sat32(input longint v);
		longint r;
		if (v > 64'sd2147483647)
			r = 64'sd2147483647;
		else if (v < -64'sd2147483648)
			r = -64'sd2147483648;
		else
			r = v;
		return r;
	endfunction

	// Q15 times Q15 into Q31
	function automatic longint fracMult(input int a, input int b);
		return sat32(longint'(a) * longint'(b) * 2);
	endfunction

	task automatic computeModel();
		longint acc;
		int past;
		for (int n = 0; n < frame; n++)
		begin
			acc = fracMult(coefs[0], xs[n]);
			for (int j = 1; j <= order; j++)
			begin
				// Before the subframe, past outputs come from the filter memory
				past = (n >= j) ? yExp[n - j] : fmem[order + n - j];
				acc = sat32(acc - fracMult(coefs[j], past));
			end
			acc = sat32(acc * (64'sd1 << `SYN_SHIFT));
			acc = sat32(acc + 64'sd32768);
			yExp[n] = int'(acc >>> 16);
		end
	endtask

	task automatic randomJob();
		coefs[0] = 2048 + ($random(seed) & 4095);
		for (int j = 1; j <= order; j++)
			coefs[j] = $random(seed) % 512;
		for (int n = 0; n < frame; n++)
			xs[n] = $random(seed) % 8192;
		for (int k = 0; k < order; k++)
			fmem[k] = $random(seed) % 4096;
	endtask

	//////////////////////////////
	// Filter runs
	//////////////////////////////

	task automatic runFilter(input logic upd, input logic injectStart);
		int startCount;
		startCount = doneCount;
		@(posedge clk);
		#1;
		host = '0;
		xAddr = xBase;
		aAddr = aBase;
		yAddr = yBase;
		fMemAddr = fBase;
		update = upd;
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		if (injectStart)
		begin
			// Second start mid-run, with other bases, must be ignored
			repeat (200) @(posedge clk);
			#1;
			yAddr = yAlt;
			update = ~upd;
			start = 1'b1;
			@(posedge clk);
			#1;
			start = 1'b0;
		end
		while (doneCount == startCount)
			@(negedge clk);
		repeat (4) @(posedge clk);
		assert (doneCount == startCount + 1)
			else failText("done did not pulse exactly once for one accepted start");
	endtask

	task automatic checkOutputs(input logic upd);
		int expected;
		for (int n = 0; n < frame; n++)
			checkWord(yBase + `SYN_ADDR_W'(n), 32'(yExp[n]), $sformatf("y[%0d]", n));
		for (int k = 0; k < order; k++)
		begin
			expected = upd ? yExp[frame - order + k] : fmem[k];
			checkWord(fBase + `SYN_ADDR_W'(k), 32'(expected), $sformatf("fmem[%0d]", k));
		end
	endtask

	initial
	begin
		logic [`SYN_ADDR_W-1:0] addr;
		logic [31:0] data;
		logic [31:0] got;
		seed = 13;
		reset = 1'b1;
		start = 1'b0;
		xAddr = '0;
		aAddr = '0;
		yAddr = '0;
		fMemAddr = '0;
		update = 1'b0;
		host = '0;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
		@(posedge clk);
		#1;
		assert (done == 1'b0 && doneCount == 0)
			else failText("done is not low after reset");

		// Host port write and read back
		for (int i = 0; i < 32; i++)
		begin
			addr = `SYN_ADDR_W'($random(seed));
			data = $random(seed);
			writeWord(addr, data);
			readWord(addr, got);
			assert (got === data)
				else failMismatch($sformatf("memIn at %h", addr), data, got);
		end

		// Identity filter
		for (int j = 0; j <= order; j++)
			coefs[j] = 0;
		coefs[0] = 4096;
		for (int k = 0; k < order; k++)
			fmem[k] = 0;
		for (int n = 0; n < frame; n++)
			xs[n] = $random(seed) % 32768;
		loadJob();
		runFilter(1'b0, 1'b0);
		for (int n = 0; n < frame; n++)
			checkWord(yBase + `SYN_ADDR_W'(n), 32'(xs[n]), $sformatf("y[%0d]", n));

		// Random taps, no update
		randomJob();
		loadJob();
		computeModel();
		runFilter(1'b0, 1'b0);
		checkOutputs(1'b0);

		// Saturation
		for (int j = 1; j <= order; j++)
			coefs[j] = 0;
		coefs[0] = 32767;
		for (int k = 0; k < order; k++)
			fmem[k] = 0;
		for (int n = 0; n < frame; n++)
		begin
			xs[n] = 16384 + ($random(seed) & 16383);
			if ($random(seed) & 1)
				xs[n] = -xs[n];
		end
		loadJob();
		computeModel();
		runFilter(1'b0, 1'b0);
		checkOutputs(1'b0);
		// Clamp level follows the sign of the input
		for (int n = 0; n < frame; n++)
			checkWord(yBase + `SYN_ADDR_W'(n), (xs[n] > 0) ? 32'h00007fff : 32'hffff8000,
				$sformatf("clamped y[%0d]", n));

		// Filter memory update
		randomJob();
		loadJob();
		computeModel();
		runFilter(1'b1, 1'b0);
		checkOutputs(1'b1);

		// Start while busy
		randomJob();
		loadJob();
		computeModel();
		runFilter(1'b0, 1'b1);
		checkOutputs(1'b0);

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: synFilt.f
+incdir+hdl
hdl/synFiltPkg.sv
hdl/fixedPointAlu.sv
hdl/longShiftLeft.sv
hdl/scratchMemory.sv
hdl/synFiltControl.sv
hdl/synFiltPipe.sv
sim/synFiltTb.sv
